/* fetch_top.f */
fetch_pkg.sv
fetch_preif.sv
fetch_if_stage.sv
fetch_inst_buffer.sv
fetch_top.sv
tb_wb_mem.sv
fetch_top_asserts.sv
tb_fetch_top.sv

/* Bender.yml */
package:
  name: fetch_top

sources:
  - fetch_pkg.sv
  - fetch_preif.sv
  - fetch_if_stage.sv
  - fetch_inst_buffer.sv
  - fetch_top.sv
  - target: test
    files:
      - tb_wb_mem.sv
      - fetch_top_asserts.sv
      - tb_fetch_top.sv

/* tb_fetch_top.sv */
// directed testbench for the fetch front end, run as the simulation top with the memory model
`timescale 1ns/1ps

module tb_fetch_top import fetch_pkg::*; ();

    localparam int MAX_WAIT    = 3;
    // instructions accepted over all tests
    localparam int TOTAL_INST  = 66;
    localparam int CYCLE_LIMIT = TOTAL_INST * (MAX_WAIT + 3) * 4 + 300;

    logic               clk;
    logic               reset_i;
    logic               flush_i;
    logic [PC_W-1:0]    flush_pc_i;
    logic               interrupt_i;
    logic               id_allowin_i;
    logic               wb_cyc_o;
    logic               wb_stb_o;
    logic [PC_W-1:0]    wb_adr_o;
    logic [FETCH_W-1:0] wb_dat_i;
    logic               wb_ack_i;
    logic               wb_err_i;
    logic               line1_valid_o;
    logic [PC_W-1:0]    line1_pc_o;
    logic [INST_W-1:0]  line1_inst_o;
    logic [EXC_W-1:0]   line1_exc_o;
    logic               line2_valid_o;
    logic [PC_W-1:0]    line2_pc_o;
    logic [INST_W-1:0]  line2_inst_o;

    // memory controls
    logic [1:0]         wait_sel;
    logic               err_en;
    logic [PC_W-1:0]    err_adr;

    // stimulus state
    logic [15:0]        lfsr_q = 16'd79;
    logic               bp_bit;
    logic [1:0]         wait_rnd;
    bit                 bp_en;
    bit                 slow;
    bit                 stale_en;
    logic [PC_W-1:0]    stale_pc;
    int                 err_cnt;
    int                 check_cnt;
    int                 cycle_cnt;

    // expected stream, one entry per instruction
    logic [PC_W-1:0]    exp_pc_q[$];
    logic [EXC_W-1:0]   exp_exc_q[$];

    fetch_top #(.RESET_PC(RESET_PC_DEFAULT)) fetch_top_inst (.*);

    tb_wb_mem mem_inst (
        .clk       (clk),
        .reset_i   (reset_i),
        .cyc_i     (wb_cyc_o),
        .stb_i     (wb_stb_o),
        .adr_i     (wb_adr_o),
        .wait_i    (wait_sel),
        .err_en_i  (err_en),
        .err_adr_i (err_adr),
        .dat_o     (wb_dat_i),
        .ack_o     (wb_ack_i),
        .err_o     (wb_err_i)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // fibonacci, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // memory word at an aligned pc
    function automatic logic [INST_W-1:0] inst_at(input logic [PC_W-1:0] pc);
        return {pc[PC_W-1:2], 2'b00} ^ 32'hA5A5_0000;
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        err_cnt++;
        $display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
    endtask

    task automatic expect_line(input logic [PC_W-1:0] pc, input logic [EXC_W-1:0] exc);
        exp_pc_q.push_back(pc);
        exp_exc_q.push_back(exc);
    endtask

    task automatic expect_stream(input logic [PC_W-1:0] start, input int n);
        for (int i = 0; i < n; i++) begin
            expect_line(start + PC_W'(4 * i), '0);
        end
    endtask

    // decode side, one random bit per cycle plus two for the wait states
    always @(posedge clk) begin
        lfsr_q = lfsr_step(lfsr_q);
        bp_bit = lfsr_q[0];
        lfsr_q = lfsr_step(lfsr_q);
        wait_rnd[0] = lfsr_q[0];
        lfsr_q = lfsr_step(lfsr_q);
        wait_rnd[1] = lfsr_q[0];
        id_allowin_i <= !reset_i && (exp_pc_q.size() != 0) && (!bp_en || bp_bit);
        wait_sel     <= slow ? 2'(MAX_WAIT) : wait_rnd;
    end

    // compare an accepted item with the head of the model
    task automatic check_accept();
        logic [PC_W-1:0]  pc1;
        logic [PC_W-1:0]  pc2;
        logic [EXC_W-1:0] exc1;
        logic             pair;
        if (exp_pc_q.size() == 0) begin
            err_cnt++;
            $display("instruction at pc %h accepted while none was expected", line1_pc_o);
        end else begin
            pc1  = exp_pc_q.pop_front();
            exc1 = exp_exc_q.pop_front();
            pair = !pc1[2] && (exc1 == '0);
            check_cnt++;
            assert (line1_pc_o == pc1) else report_mismatch("line1 pc", line1_pc_o, pc1);
            assert (line1_exc_o == exc1) else report_mismatch("line1 exc", line1_exc_o, exc1);
            if (exc1 == '0) begin
                assert (line1_inst_o == inst_at(pc1))
                    else report_mismatch("line1 inst", line1_inst_o, inst_at(pc1));
            end
            // interrupt and misaligned items never reach the bus
            if (exc1[EXC_ADEF] || exc1[EXC_INT]) begin
                assert (!wb_cyc_o)
                    else report_mismatch("wb_cyc_o with exception", wb_cyc_o, 1'b0);
            end
            assert (line2_valid_o == pair)
                else report_mismatch("line2 valid", line2_valid_o, pair);
            if (pair && line2_valid_o) begin
                if (exp_pc_q.size() == 0) begin
                    err_cnt++;
                    $display("line 2 at pc %h accepted while none was expected", line2_pc_o);
                end else begin
                    pc2 = exp_pc_q.pop_front();
                    void'(exp_exc_q.pop_front());
                    check_cnt++;
                    assert (line2_pc_o == pc2)
                        else report_mismatch("line2 pc", line2_pc_o, pc2);
                    assert (line2_inst_o == inst_at(pc2))
                        else report_mismatch("line2 inst", line2_inst_o, inst_at(pc2));
                end
            end
        end
    endtask

    // sampled mid-cycle, inputs and outputs settled
    always @(negedge clk) begin
        if (!reset_i && line1_valid_o) begin
            if (stale_en) begin
                assert (line1_pc_o != stale_pc)
                    else report_mismatch("flushed line presented, pc", line1_pc_o, stale_pc);
            end
            if (id_allowin_i) begin
                check_accept();
            end
        end
    end

    // optional check that no bus cycle runs meanwhile
    task automatic wait_drained(input bit bus_idle);
        while (exp_pc_q.size() != 0) begin
            @(negedge clk);
            if (bus_idle) begin
                assert (!wb_cyc_o) else report_mismatch("wb_cyc_o", wb_cyc_o, 1'b0);
            end
        end
    endtask

    // after an exception item, no bus traffic and nothing presented
    task automatic check_halted(input int n);
        repeat (n) begin
            @(negedge clk);
            assert (!wb_cyc_o) else report_mismatch("wb_cyc_o halted", wb_cyc_o, 1'b0);
            assert (!line1_valid_o)
                else report_mismatch("line1_valid_o halted", line1_valid_o, 1'b0);
        end
    endtask

    task automatic flush_to(input logic [PC_W-1:0] target);
        @(posedge clk);
        flush_i    <= 1'b1;
        flush_pc_i <= target;
        @(posedge clk);
        flush_i    <= 1'b0;
    endtask

    task automatic run_sequential();
        @(negedge clk);
        expect_stream(RESET_PC_DEFAULT, 16);
        wait_drained(1'b0);
    endtask

    task automatic run_backpressure();
        bp_en = 1'b1;
        @(negedge clk);
        expect_stream(RESET_PC_DEFAULT + 32'h40, 40);
        wait_drained(1'b0);
        bp_en = 1'b0;
    endtask

    task automatic run_flush_in_flight();
        slow     = 1'b1;
        stale_pc = 32'h2000;
        stale_en = 1'b1;
        flush_to(32'h2000);
        // the stale read is on the bus
        do @(negedge clk); while (!(wb_cyc_o && wb_adr_o == 32'h2000));
        flush_to(32'h3004);
        assert (wb_cyc_o) else report_mismatch("wb_cyc_o at flush", wb_cyc_o, 1'b1);
        @(negedge clk);
        slow = 1'b0;
        expect_line(32'h3004, '0);
        expect_stream(32'h3008, 4);
        wait_drained(1'b0);
        stale_en = 1'b0;
    endtask

    task automatic run_misaligned();
        flush_to(32'h4002);
        @(negedge clk);
        expect_line(32'h4002, 3'b1 << EXC_ADEF);
        wait_drained(1'b0);
        check_halted(16);
    endtask

    task automatic run_interrupt();
        @(posedge clk);
        interrupt_i <= 1'b1;
        flush_to(32'h5000);
        @(negedge clk);
        expect_line(32'h5000, 3'b1 << EXC_INT);
        wait_drained(1'b1);
        @(posedge clk);
        interrupt_i <= 1'b0;
        check_halted(8);
    endtask

    task automatic run_bus_error();
        err_adr = 32'h6008;
        err_en  = 1'b1;
        flush_to(32'h6000);
        @(negedge clk);
        expect_stream(32'h6000, 2);
        expect_line(32'h6008, 3'b1 << EXC_IBE);
        wait_drained(1'b0);
        check_halted(8);
        err_en = 1'b0;
    endtask

    // run limit
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        reset_i      = 1'b1;
        flush_i      = 1'b0;
        flush_pc_i   = '0;
        interrupt_i  = 1'b0;
        id_allowin_i = 1'b0;
        wait_sel     = '0;
        err_en       = 1'b0;
        err_adr      = '0;
        bp_en        = 1'b0;
        slow         = 1'b0;
        stale_en     = 1'b0;
        stale_pc     = '0;
        err_cnt      = 0;
        check_cnt    = 0;
        repeat (3) @(posedge clk);
        reset_i <= 1'b0;
        run_sequential();
        run_backpressure();
        run_flush_in_flight();
        run_misaligned();
        run_interrupt();
        run_bus_error();
        repeat (4) @(posedge clk);
        $display("checks %0d, errors %0d, assertion failures %0d", check_cnt, err_cnt,
                 fetch_top_inst.asserts_inst.fail_cnt);
        if (err_cnt == 0 && fetch_top_inst.asserts_inst.fail_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* fetch_top_asserts.sv */
// bus protocol and output checks for the fetch front end, bound into fetch_top by the testbench
`timescale 1ns/1ps

module fetch_top_asserts (
    input logic clk,
    input logic reset_i,
    input logic wb_cyc_o,
    input logic wb_stb_o,
    input logic wb_ack_i,
    input logic wb_err_i,
    input logic line1_valid_o,
    input logic line2_valid_o
);

    // failures seen, read by the testbench for its verdict
    int fail_cnt = 0;

    // classic cycle, strobe is the cycle
    stb_is_cyc: assert property (@(posedge clk) disable iff (reset_i) wb_stb_o == wb_cyc_o)
        else begin
            fail_cnt++;
            $error("wb_stb_o differs from wb_cyc_o");
        end

    // no abandoning a request before the slave answers
    cyc_held: assert property (@(posedge clk) disable iff (reset_i)
        wb_cyc_o && !wb_ack_i && !wb_err_i |=> wb_cyc_o)
        else begin
            fail_cnt++;
            $error("wb_cyc_o dropped without ack or err");
        end

    // outputs quiet once reset has been applied
    quiet_in_reset: assert property (@(posedge clk) reset_i |=> !line1_valid_o && !line2_valid_o)
        else begin
            fail_cnt++;
            $error("line valid high during reset");
        end

    // line 2 never goes alone
    line2_needs_line1: assert property (@(posedge clk) disable iff (reset_i)
        line2_valid_o |-> line1_valid_o)
        else begin
            fail_cnt++;
            $error("line2_valid_o without line1_valid_o");
        end

endmodule

bind fetch_top fetch_top_asserts asserts_inst (
    .clk           (clk),
    .reset_i       (reset_i),
    .wb_cyc_o      (wb_cyc_o),
    .wb_stb_o      (wb_stb_o),
    .wb_ack_i      (wb_ack_i),
    .wb_err_i      (wb_err_i),
    .line1_valid_o (line1_valid_o),
    .line2_valid_o (line2_valid_o)
);

/* tb_wb_mem.sv */
// Wishbone classic read slave for the fetch testbench, address-derived data and one error address
`timescale 1ns/1ps

module tb_wb_mem import fetch_pkg::*; (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               cyc_i,
    input  logic               stb_i,
    input  logic [PC_W-1:0]    adr_i,
    input  logic [1:0]         wait_i,
    input  logic               err_en_i,
    input  logic [PC_W-1:0]    err_adr_i,
    output logic [FETCH_W-1:0] dat_o,
    output logic               ack_o,
    output logic               err_o
);

    // wait cycles already spent on the current request
    logic [1:0] cnt_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_o <= 1'b0;
            err_o <= 1'b0;
            cnt_q <= '0;
        end else if (cyc_i && stb_i && !ack_o && !err_o) begin
            // wait count may change each cycle, stop once it is reached
            if (cnt_q >= wait_i) begin
                cnt_q <= '0;
                if (err_en_i && adr_i == err_adr_i) begin
                    err_o <= 1'b1;
                end else begin
                    ack_o <= 1'b1;
                    // each word is its own address with a fixed pattern on top
                    dat_o <= {(adr_i + 32'd4) ^ 32'hA5A5_0000, adr_i ^ 32'hA5A5_0000};
                end
            end else begin
                cnt_q <= cnt_q + 2'd1;
            end
        end else begin
            // one-cycle response, master drops or restarts on that edge
            ack_o <= 1'b0;
            err_o <= 1'b0;
        end
    end

endmodule

/* fetch_top.sv */
// top level of the fetch front end, connects pre-fetch, fetch stage and buffer to bus and decode
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; #(
    parameter logic [PC_W-1:0] RESET_PC = RESET_PC_DEFAULT
) (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               flush_i,
    input  logic [PC_W-1:0]    flush_pc_i,
    input  logic               interrupt_i,
    input  logic               id_allowin_i,
    output logic               wb_cyc_o,
    output logic               wb_stb_o,
    output logic [PC_W-1:0]    wb_adr_o,
    input  logic [FETCH_W-1:0] wb_dat_i,
    input  logic               wb_ack_i,
    input  logic               wb_err_i,
    output logic               line1_valid_o,
    output logic [PC_W-1:0]    line1_pc_o,
    output logic [INST_W-1:0]  line1_inst_o,
    output logic [EXC_W-1:0]   line1_exc_o,
    output logic               line2_valid_o,
    output logic [PC_W-1:0]    line2_pc_o,
    output logic [INST_W-1:0]  line2_inst_o
);

    // pre-fetch to stage
    logic               load;
    logic [PC_W-1:0]    load_pc;
    logic [EXC_W-1:0]   entry_exc;

    // stage back to pre-fetch
    logic               if_allowin;
    logic               if_taken;
    logic               if_pair;

    // buffer to stage
    logic               buf_ok;
    logic [FETCH_W-1:0] buf_data;

    // line 1 valid equals stage valid whenever ack or buffered data is in
    logic               line1_valid;

    fetch_preif #(
        .RESET_PC (RESET_PC)
    ) preif_inst (
        .clk          (clk),
        .reset_i      (reset_i),
        .flush_i      (flush_i),
        .flush_pc_i   (flush_pc_i),
        .interrupt_i  (interrupt_i),
        .if_allowin_i (if_allowin),
        .if_taken_i   (if_taken),
        .if_pair_i    (if_pair),
        .wb_ack_i     (wb_ack_i),
        .wb_err_i     (wb_err_i),
        .wb_cyc_o     (wb_cyc_o),
        .wb_stb_o     (wb_stb_o),
        .wb_adr_o     (wb_adr_o),
        .load_o       (load),
        .pc_o         (load_pc),
        .entry_exc_o  (entry_exc)
    );

    fetch_if_stage if_stage_inst (
        .clk           (clk),
        .reset_i       (reset_i),
        .flush_i       (flush_i),
        .id_allowin_i  (id_allowin_i),
        .load_i        (load),
        .pc_i          (load_pc),
        .entry_exc_i   (entry_exc),
        .wb_dat_i      (wb_dat_i),
        .wb_ack_i      (wb_ack_i),
        .wb_err_i      (wb_err_i),
        .buf_ok_i      (buf_ok),
        .buf_data_i    (buf_data),
        .if_allowin_o  (if_allowin),
        .if_taken_o    (if_taken),
        .if_pair_o     (if_pair),
        .line1_valid_o (line1_valid),
        .line1_pc_o    (line1_pc_o),
        .line1_inst_o  (line1_inst_o),
        .line1_exc_o   (line1_exc_o),
        .line2_valid_o (line2_valid_o),
        .line2_pc_o    (line2_pc_o),
        .line2_inst_o  (line2_inst_o)
    );

    fetch_inst_buffer inst_buffer_inst (
        .clk           (clk),
        .reset_i       (reset_i),
        .flush_i       (flush_i),
        .stage_valid_i (line1_valid),
        .id_allowin_i  (id_allowin_i),
        .wb_ack_i      (wb_ack_i),
        .wb_dat_i      (wb_dat_i),
        .buf_ok_o      (buf_ok),
        .buf_data_o    (buf_data)
    );

    assign line1_valid_o = line1_valid;

endmodule

/* fetch_inst_buffer.sv */
// holds a fetched doubleword that decode refused, so the fetch stage can present it on later cycles
`timescale 1ns/1ps

module fetch_inst_buffer import fetch_pkg::*; (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               flush_i,
    input  logic               stage_valid_i,
    input  logic               id_allowin_i,
    input  logic               wb_ack_i,
    input  logic [FETCH_W-1:0] wb_dat_i,
    output logic               buf_ok_o,
    output logic [FETCH_W-1:0] buf_data_o
);

    logic               ok_q;
    logic [FETCH_W-1:0] data_q;
    logic               capture;
    logic               take;

    // ack arrived but decode is stalled, park it
    assign capture = stage_valid_i && wb_ack_i && !id_allowin_i;

    // stage item handed over, from the bus or from here
    assign take = stage_valid_i && id_allowin_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ok_q <= 1'b0;
        end else if (flush_i) begin
            ok_q <= 1'b0;
        end else if (capture) begin
            ok_q <= 1'b1;
        end else if (take) begin
            ok_q <= 1'b0;
        end
    end

    // payload only written on capture
    always_ff @(posedge clk) begin
        if (capture) begin
            data_q <= wb_dat_i;
        end
    end

    assign buf_ok_o   = ok_q;
    assign buf_data_o = data_q;

endmodule

/* fetch_if_stage.sv */
// fetch stage, marks exceptions, picks instruction data and handshakes the two lines to decode
`timescale 1ns/1ps

module fetch_if_stage import fetch_pkg::*; (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               flush_i,
    input  logic               id_allowin_i,
    input  logic               load_i,
    input  logic [PC_W-1:0]    pc_i,
    input  logic [EXC_W-1:0]   entry_exc_i,
    input  logic [FETCH_W-1:0] wb_dat_i,
    input  logic               wb_ack_i,
    input  logic               wb_err_i,
    input  logic               buf_ok_i,
    input  logic [FETCH_W-1:0] buf_data_i,
    output logic               if_allowin_o,
    output logic               if_taken_o,
    output logic               if_pair_o,
    output logic               line1_valid_o,
    output logic [PC_W-1:0]    line1_pc_o,
    output logic [INST_W-1:0]  line1_inst_o,
    output logic [EXC_W-1:0]   line1_exc_o,
    output logic               line2_valid_o,
    output logic [PC_W-1:0]    line2_pc_o,
    output logic [INST_W-1:0]  line2_inst_o
);

    logic               valid_q;
    logic [PC_W-1:0]    pc_q;
    logic [EXC_W-1:0]   exc_q;
    logic               exc_any;
    logic               ready_go;
    logic               allowin;
    logic               taken;
    logic               pair_ok;
    logic [FETCH_W-1:0] fetch_data;
    logic [INST_W-1:0]  lo_word;
    logic [INST_W-1:0]  hi_word;

    assign exc_any = |exc_q;

    // data in hand, either live from the bus or parked in the buffer
    // exception items carry no data and are let through as they are
    assign ready_go = wb_ack_i || buf_ok_i || exc_any;

    // empty, or emptying on this edge
    assign allowin = !valid_q || (ready_go && id_allowin_i);
    assign taken   = valid_q && ready_go && id_allowin_i;

    // second slot only for an aligned doubleword start without exception
    assign pair_ok = !pc_q[2] && !exc_any;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
            exc_q   <= '0;
        end else if (load_i) begin
            // pre-fetch only loads into room, a flush edge included
            valid_q <= 1'b1;
            exc_q   <= entry_exc_i;
        end else if (flush_i || taken) begin
            valid_q <= 1'b0;
            exc_q   <= '0;
        end else if (valid_q && wb_err_i) begin
            // bus error, present it as IBE from the next cycle
            exc_q[EXC_IBE] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load_i) begin
            pc_q <= pc_i;
        end
    end

    // buffered copy wins, the bus is idle by then
    assign fetch_data = buf_ok_i ? buf_data_i : wb_dat_i;
    assign lo_word    = fetch_data[INST_W-1:0];
    assign hi_word    = fetch_data[FETCH_W-1:INST_W];

    assign if_allowin_o = allowin;
    assign if_taken_o   = taken;
    assign if_pair_o    = pair_ok;

    // line 1 from the half picked by pc[2]
    assign line1_valid_o = valid_q && ready_go;
    assign line1_pc_o    = pc_q;
    assign line1_inst_o  = pc_q[2] ? hi_word : lo_word;
    assign line1_exc_o   = exc_q;

    // line 2 is always the upper word and never carries an exception
    assign line2_valid_o = valid_q && ready_go && pair_ok;
    assign line2_pc_o    = pc_q + INST_BYTES;
    assign line2_inst_o  = hi_word;

endmodule

/* fetch_preif.sv */
// pre-fetch stage, holds the fetch PC and runs one Wishbone classic read per fetch into the stage
`timescale 1ns/1ps

module fetch_preif import fetch_pkg::*; #(
    parameter logic [PC_W-1:0] RESET_PC = RESET_PC_DEFAULT
) (
    input  logic             clk,
    input  logic             reset_i,
    input  logic             flush_i,
    input  logic [PC_W-1:0]  flush_pc_i,
    input  logic             interrupt_i,
    input  logic             if_allowin_i,
    input  logic             if_taken_i,
    input  logic             if_pair_i,
    input  logic             wb_ack_i,
    input  logic             wb_err_i,
    output logic             wb_cyc_o,
    output logic             wb_stb_o,
    output logic [PC_W-1:0]  wb_adr_o,
    output logic             load_o,
    output logic [PC_W-1:0]  pc_o,
    output logic [EXC_W-1:0] entry_exc_o
);

    // pc of the stage item, or the next one to load when the stage is empty
    logic [PC_W-1:0]  pc_q;
    logic [PC_W-1:0]  seq_pc;
    logic [PC_W-1:0]  fetch_pc;
    logic [PC_W-1:0]  adr_q;
    // bus cycle open
    logic             cyc_q;
    // open cycle belongs to flushed work, its response is ignored
    logic             cancel_q;
    // exception seen, no more loads until a flush
    logic             halt_q;
    logic             bus_done;
    logic             bus_free;
    logic             load;
    logic             exc_load;
    logic             open_cycle;
    logic             err_hit;
    logic [EXC_W-1:0] entry_exc;

    always_comb begin
        // sequential step once the stage hands its item to decode
        seq_pc = pc_q;
        if (if_taken_i) begin
            seq_pc = pc_q + (if_pair_i ? PAIR_BYTES : INST_BYTES);
        end
    end

    // flush target wins over the sequential pc
    assign fetch_pc = flush_i ? flush_pc_i : seq_pc;

    // cycle ends on the same edge as its ack or err
    assign bus_done = wb_ack_i || wb_err_i;
    assign bus_free = !cyc_q || bus_done;

    // a flush clears the stage so it always has room
    assign load = bus_free && (flush_i || (if_allowin_i && !halt_q));

    always_comb begin
        entry_exc           = '0;
        entry_exc[EXC_INT]  = interrupt_i;
        entry_exc[EXC_ADEF] = |fetch_pc[1:0];
    end

    // exception items skip the bus entirely
    assign exc_load   = load && (|entry_exc);
    assign open_cycle = load && !(|entry_exc);

    // error on a live cycle, the stage will mark it as IBE
    assign err_hit = cyc_q && wb_err_i && !cancel_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q     <= RESET_PC;
            cyc_q    <= 1'b0;
            cancel_q <= 1'b0;
            halt_q   <= 1'b0;
        end else begin
            pc_q <= fetch_pc;

            if (open_cycle) begin
                cyc_q <= 1'b1;
            end else if (bus_done) begin
                cyc_q <= 1'b0;
            end

            // read still in flight at flush, let it finish and drop it
            if (flush_i && cyc_q && !bus_done) begin
                cancel_q <= 1'b1;
            end else if (bus_done) begin
                cancel_q <= 1'b0;
            end

            if (flush_i) begin
                halt_q <= exc_load;
            end else if (exc_load || err_hit) begin
                halt_q <= 1'b1;
            end
        end
    end

    // address held stable for the whole cycle
    always_ff @(posedge clk) begin
        if (open_cycle) begin
            adr_q <= {fetch_pc[PC_W-1:DW_OFFSET_W], {DW_OFFSET_W{1'b0}}};
        end
    end

    assign wb_cyc_o    = cyc_q;
    assign wb_stb_o    = cyc_q;
    assign wb_adr_o    = adr_q;
    assign load_o      = load;
    assign pc_o        = fetch_pc;
    assign entry_exc_o = entry_exc;

endmodule

/* fetch_pkg.sv */
// shared widths, exception bit positions and fetch step sizes, imported by the RTL and testbench
package fetch_pkg;

    // fetch address and program counter width
    localparam int PC_W = 32;

    // one instruction word
    localparam int INST_W = 32;

    // bus data width, one doubleword carrying two instructions
    localparam int FETCH_W = 64;

    // exception vector travelling with line 1
    localparam int EXC_W = 3;

    // pending interrupt, sampled when the item enters the stage
    localparam int EXC_INT = 0;

    // misaligned fetch address, pc[1:0] not zero
    localparam int EXC_ADEF = 1;

    // bus error returned by the slave
    localparam int EXC_IBE = 2;

    // where the front end starts unless the top level overrides it
    localparam logic [PC_W-1:0] RESET_PC_DEFAULT = 32'h0000_1000;

    // pc step for a single line
    localparam logic [PC_W-1:0] INST_BYTES = PC_W'(4);

    // pc step when both lines of a doubleword go out together
    localparam logic [PC_W-1:0] PAIR_BYTES = PC_W'(8);

    // low address bits dropped on the bus, doubleword granularity
    localparam int DW_OFFSET_W = 3;

endpackage
